/* hdl/adc_capture_consts.svh */
// shared ADC capture constants, included by the packages, the RTL and the testbench
`ifndef ADC_CAPTURE_CONSTS_SVH
`define ADC_CAPTURE_CONSTS_SVH

// bits in one filtered sample from each ADC
`define ADC_BITS 24

// number of ADCs read in parallel on shared MCLK, SCKA and SYNC
`define ADC_CHANNELS 4

// capture_clk cycles in one MCLK period, the cycle counter is 5 bits so keep this at 32 or below
`define ADC_CYCLES 20

// cycles with MCLK high, the SPI bus stays quiet while the ADC converts
`define CONVERT_CYCLES 12

// SCKA bit slots after each conversion (distributed read)
`define ACQUIRE_NBITS 3

// conversions per filtered word
// times ACQUIRE_NBITS this has to cover ADC_BITS
`define ADC_DECIMATE 8

// width of the output stream word, samples are left-justified in it
`define OUT_WIDTH 32

`endif

/* hdl/adc_timing_pkg.sv */
// sequencer state and acquisition mode types shared by the ADC timing logic
package adc_timing_pkg;

   // position of the sequencer within one MCLK period
   // reset only appears after external_reset, the rest loop once per MCLK
   typedef enum logic [2:0] {
      seq_reset   = 3'd0,
      seq_start   = 3'd1,
      seq_convert = 3'd2,
      seq_sync    = 3'd3,
      seq_acquire = 3'd4,
      seq_wait    = 3'd5
   } seq_state_t;

   // outer position within a full word
   // sync mode lasts from the first start of a word until its first acquire slot
   typedef enum logic [1:0] {
      mode_acquire = 2'd0,
      mode_wait    = 2'd1,
      mode_sync    = 2'd2
   } acq_mode_t;

   // capture_clk cycle count within one MCLK period
   typedef logic [4:0] cycle_t;

endpackage

/* hdl/adc_data_pkg.sv */
// sample, chain link and output word types for the ADC capture datapath
`include "adc_capture_consts.svh"

package adc_data_pkg;

   // one filtered sample as it comes off SDOA, MSB first
   typedef logic [`ADC_BITS-1:0] sample_t;

   // one link of the output chain
   // valid marks a word that still has to go out on the stream
   typedef struct packed {
      logic    valid;
      sample_t data;
   } chain_t;

   // word on the output stream, sample in the top bits
   typedef logic [`OUT_WIDTH-1:0] out_word_t;

endpackage

/* hdl/adc_sequencer.sv */
// conversion sequencer, steps through each MCLK period and tracks the word-level mode
`include "adc_capture_consts.svh"

module adc_sequencer (
   input  logic                       capture_clk,
   input  logic                       external_reset,
   input  logic                       word_loaded,
   output adc_timing_pkg::seq_state_t state,
   output adc_timing_pkg::acq_mode_t  mode,
   output logic                       cycle_lsb,
   output logic                       decimate_wrap
);

   // counter runs 0..ADC_DECIMATE, zero only during the sync conversion of a word
   localparam int dec_w = $clog2(`ADC_DECIMATE + 1);

   // cycle positions where the state moves on, the state lags the counter by one cycle
   localparam adc_timing_pkg::cycle_t convert_end_at =
      adc_timing_pkg::cycle_t'(`CONVERT_CYCLES - 1);
   // one SCKA slot after the conversion is kept for the SYNC pulse
   localparam adc_timing_pkg::cycle_t sync_end_at =
      adc_timing_pkg::cycle_t'(`CONVERT_CYCLES + 1);
   // each acquired bit takes two cycles
   localparam adc_timing_pkg::cycle_t acquire_end_at =
      adc_timing_pkg::cycle_t'(`CONVERT_CYCLES + 1 + 2 * `ACQUIRE_NBITS);
   localparam adc_timing_pkg::cycle_t wait_end_at =
      adc_timing_pkg::cycle_t'(`ADC_CYCLES - 1);

   adc_timing_pkg::cycle_t cycle;
   logic [dec_w-1:0]       decimate_count;
   logic                   convert_end;
   logic                   sync_end;
   logic                   acquire_end;
   logic                   wait_end;

   assign convert_end = (cycle == convert_end_at);
   assign sync_end    = (cycle == sync_end_at);
   assign acquire_end = (cycle == acquire_end_at);
   assign wait_end    = (cycle == wait_end_at);

   // the lsb of the cycle count is the SCKA phase
   assign cycle_lsb     = cycle[0];
   assign decimate_wrap = (decimate_count == '0);

   // free-running position within the MCLK period, held at zero in reset
   always_ff @(posedge capture_clk) begin
      if (external_reset || state == adc_timing_pkg::seq_reset || wait_end) begin
         cycle <= '0;
      end else begin
         cycle <= cycle + 5'd1;
      end
   end

   // decimation count and mode
   // the count drops at every start and reaches zero on the start that opens a new word
   always_ff @(posedge capture_clk) begin
      if (external_reset || state == adc_timing_pkg::seq_reset) begin
         // first start after reset goes straight into a sync conversion
         decimate_count <= dec_w'(1);
         mode           <= adc_timing_pkg::mode_sync;
      end else if (state == adc_timing_pkg::seq_start) begin
         decimate_count <= decimate_count - 1'b1;
         // a new word wins over a load that lands on the same start
         if (decimate_count == dec_w'(1)) begin
            mode <= adc_timing_pkg::mode_sync;
         end else if (word_loaded) begin
            mode <= adc_timing_pkg::mode_wait;
         end
      end else begin
         // reload once the sync slot of the new word is reached
         if (state == adc_timing_pkg::seq_sync && decimate_wrap) begin
            decimate_count <= dec_w'(`ADC_DECIMATE);
         end
         if (word_loaded) begin
            mode <= adc_timing_pkg::mode_wait;
         end else if (state == adc_timing_pkg::seq_acquire &&
                      mode == adc_timing_pkg::mode_sync) begin
            // sync mode is held into the first acquire slot so that SCKA skips one pulse
            mode <= adc_timing_pkg::mode_acquire;
         end
      end
   end

   // state only decodes the cycle position, the outputs are made in the bit gatherer
   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         state <= adc_timing_pkg::seq_reset;
      end else begin
         case (state)
            // entering through wait lines the first start up with the top of the cycle
            adc_timing_pkg::seq_reset: state <= adc_timing_pkg::seq_wait;
            adc_timing_pkg::seq_start: state <= adc_timing_pkg::seq_convert;
            adc_timing_pkg::seq_convert: begin
               // a finished word skips both sync and acquire
               if (convert_end) begin
                  state <= (mode == adc_timing_pkg::mode_wait) ? adc_timing_pkg::seq_wait
                                                               : adc_timing_pkg::seq_sync;
               end
            end
            adc_timing_pkg::seq_sync: begin
               if (sync_end) state <= adc_timing_pkg::seq_acquire;
            end
            adc_timing_pkg::seq_acquire: begin
               // without wait cycles the next conversion starts right away
               if (acquire_end) begin
                  state <= wait_end ? adc_timing_pkg::seq_start : adc_timing_pkg::seq_wait;
               end
            end
            adc_timing_pkg::seq_wait: begin
               if (wait_end) state <= adc_timing_pkg::seq_start;
            end
            default: state <= adc_timing_pkg::seq_reset;
         endcase
      end
   end

endmodule

/* hdl/adc_bit_gather.sv */
// ADC pin clocking and bit counting, turns the sequencer state into MCLK, SCKA, SYNC and load pulses
`include "adc_capture_consts.svh"

module adc_bit_gather (
   input  logic                       capture_clk,
   input  logic                       external_reset,
   input  adc_timing_pkg::seq_state_t state,
   input  adc_timing_pkg::acq_mode_t  mode,
   input  logic                       cycle_lsb,
   input  logic                       decimate_wrap,
   output logic                       adc_mclk,
   output logic                       adc_scka,
   output logic                       adc_sync,
   output logic                       shift_ena,
   output logic                       load_ena,
   output logic                       word_loaded
);

   localparam int bit_w = $clog2(`ADC_BITS);

   logic             scka_rise;
   logic [bit_w-1:0] bits_left;
   logic             load_pulse;

   // SCKA is high in odd cycles, so the next edge rises when the current cycle is even
   assign scka_rise = ~cycle_lsb;

   // the ADC moves on to the next bit on every SCKA pulse, and SYNC already puts the MSB
   // on SDOA, so both count as a bit to take in
   assign shift_ena = adc_scka | adc_sync;

   // one pulse serves both the shifters and the sequencer
   assign load_ena    = load_pulse;
   assign word_loaded = load_pulse;

   // registered pins so no runt pulses reach the ADCs
   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         adc_mclk <= 1'b0;
         adc_scka <= 1'b0;
         adc_sync <= 1'b1;
      end else begin
         // MCLK rises one cycle after start and covers the conversion time
         adc_mclk <= (state == adc_timing_pkg::seq_start) ||
                     (state == adc_timing_pkg::seq_convert);
         // first acquire slot of a word stays quiet since the MSB came with SYNC
         if (state == adc_timing_pkg::seq_acquire && mode != adc_timing_pkg::mode_sync) begin
            adc_scka <= scka_rise;
         end else begin
            adc_scka <= 1'b0;
         end
         // SYNC in reset and once per word, its falling edge realigns the ADC filter
         adc_sync <= (state == adc_timing_pkg::seq_reset) ||
                     (state == adc_timing_pkg::seq_sync &&
                      mode == adc_timing_pkg::mode_sync && scka_rise);
      end
   end

   // bits still to come in the current word, counted down to the load pulse
   // decimate_wrap holds it at the top during the quiet part of a sync conversion
   always_ff @(posedge capture_clk) begin
      if (external_reset || decimate_wrap) begin
         bits_left  <= bit_w'(`ADC_BITS - 1);
         load_pulse <= 1'b0;
      end else if (shift_ena && bits_left == '0) begin
         bits_left  <= bit_w'(`ADC_BITS - 1);
         load_pulse <= 1'b1;
      end else begin
         if (shift_ena) bits_left <= bits_left - 1'b1;
         load_pulse <= 1'b0;
      end
   end

endmodule

/* hdl/adc_channel_shifter.sv */
// per-channel SDOA shift register with its hold link in the output chain
module adc_channel_shifter (
   input  logic                  capture_clk,
   input  logic                  external_reset,
   input  logic                  sdo_bit,
   input  logic                  shift_ena,
   input  logic                  load_ena,
   input  logic                  chain_advance,
   input  adc_data_pkg::chain_t  chain_in,
   output adc_data_pkg::chain_t  chain_out
);

   adc_data_pkg::sample_t shift_reg;
   adc_data_pkg::chain_t  link;

   assign chain_out = link;

   // bits arrive MSB first, so they enter at the bottom and move up
   always_ff @(posedge capture_clk) begin
      if (shift_ena) begin
         shift_reg <= {shift_reg[$bits(shift_reg)-2:0], sdo_bit};
      end
   end

   // hold link, double buffered against the shifter
   // the next word can be gathered while this one drains
   // loads only happen on an advance, and the serializer only advances into a load
   // when the whole chain is empty
   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         link.valid <= 1'b0;
      end else if (chain_advance) begin
         if (load_ena) begin
            link.valid <= 1'b1;
            link.data  <= shift_reg;
         end else begin
            // the next channel moves down one place toward the output
            link <= chain_in;
         end
      end
   end

endmodule

/* hdl/adc_word_serializer.sv */
// output stage that drains the channel chain onto the valid/ready stream and flags lost word sets
`include "adc_capture_consts.svh"

module adc_word_serializer (
   input  logic                     capture_clk,
   input  logic                     external_reset,
   input  logic                     out_ready,
   input  logic                     load_ena,
   input  adc_data_pkg::chain_t     chain_head,
   output logic                     out_valid,
   output adc_data_pkg::out_word_t  out_data,
   output logic                     chain_advance,
   output logic                     overrun
);

   logic stage_free;
   logic take_head;
   logic load_blocked;

   // the output register can take a word when it is empty or being read this cycle
   assign stage_free = ~out_valid | out_ready;

   // links fill from the head, so an empty head means an empty chain
   // a load that meets a valid head is dropped
   assign load_blocked = load_ena & chain_head.valid;

   // an empty chain may always advance, which is also what lets a load in
   // a full chain moves only into a free output stage, and never while a load is blocked
   assign chain_advance = ~chain_head.valid | (stage_free & ~load_ena);

   assign take_head = chain_head.valid & chain_advance;

   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         out_valid <= 1'b0;
      end else if (stage_free) begin
         out_valid <= take_head;
      end
   end

   // sample goes to the top of the word with zeros below
   // data only changes when a new head is taken, so it holds while the sink stalls
   always_ff @(posedge capture_clk) begin
      if (stage_free && take_head) begin
         out_data <= adc_data_pkg::out_word_t'(chain_head.data) << (`OUT_WIDTH - `ADC_BITS);
      end
   end

   // sticky until the next external reset
   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         overrun <= 1'b0;
      end else if (load_blocked) begin
         overrun <= 1'b1;
      end
   end

endmodule

/* hdl/multi_adc_capture.sv */
// top level of the multi-channel ADC capture, one shared sequencer and one shifter per ADC
`include "adc_capture_consts.svh"

module multi_adc_capture (
   input  logic                      capture_clk,
   input  logic                      external_reset,
   input  logic [`ADC_CHANNELS-1:0]  adc_sdoa,
   input  logic                      out_ready,
   output logic                      adc_mclk,
   output logic                      adc_scka,
   output logic                      adc_sync,
   output logic                      out_valid,
   output adc_data_pkg::out_word_t   out_data,
   output logic                      overrun
);

   adc_timing_pkg::seq_state_t state;
   adc_timing_pkg::acq_mode_t  mode;
   logic                       cycle_lsb;
   logic                       decimate_wrap;
   logic                       word_loaded;
   logic                       shift_ena;
   logic                       load_ena;
   logic                       chain_advance;

   // chain[0] is the head, the entry past the last channel feeds in empty links
   adc_data_pkg::chain_t chain [0:`ADC_CHANNELS];

   assign chain[`ADC_CHANNELS] = '0;

   adc_sequencer sequencer (
      .capture_clk    (capture_clk),
      .external_reset (external_reset),
      .word_loaded    (word_loaded),
      .state          (state),
      .mode           (mode),
      .cycle_lsb      (cycle_lsb),
      .decimate_wrap  (decimate_wrap)
   );

   adc_bit_gather bit_gather (
      .capture_clk    (capture_clk),
      .external_reset (external_reset),
      .state          (state),
      .mode           (mode),
      .cycle_lsb      (cycle_lsb),
      .decimate_wrap  (decimate_wrap),
      .adc_mclk       (adc_mclk),
      .adc_scka       (adc_scka),
      .adc_sync       (adc_sync),
      .shift_ena      (shift_ena),
      .load_ena       (load_ena),
      .word_loaded    (word_loaded)
   );

   // channel 0 sits at the head, so words leave in channel order
   for (genvar ch = 0; ch < `ADC_CHANNELS; ch++) begin : g_channel
      adc_channel_shifter shifter (
         .capture_clk    (capture_clk),
         .external_reset (external_reset),
         .sdo_bit        (adc_sdoa[ch]),
         .shift_ena      (shift_ena),
         .load_ena       (load_ena),
         .chain_advance  (chain_advance),
         .chain_in       (chain[ch+1]),
         .chain_out      (chain[ch])
      );
   end

   adc_word_serializer serializer (
      .capture_clk    (capture_clk),
      .external_reset (external_reset),
      .out_ready      (out_ready),
      .load_ena       (load_ena),
      .chain_head     (chain[0]),
      .out_valid      (out_valid),
      .out_data       (out_data),
      .chain_advance  (chain_advance),
      .overrun        (overrun)
   );

endmodule

/* testbench/adc_capture_properties.sv */
// concurrent checks on the ADC pins and the output stream, bound into the capture top level
module adc_capture_properties (
   input logic                    capture_clk,
   input logic                    external_reset,
   input logic                    adc_mclk,
   input logic                    adc_scka,
   input logic                    out_valid,
   input logic                    out_ready,
   input adc_data_pkg::out_word_t out_data
);

   int failures = 0;

   // the SPI bus has to stay quiet while the ADCs convert
   scka_quiet_in_convert: assert property (@(posedge capture_clk) disable iff (external_reset)
      !(adc_scka && adc_mclk))
      else begin
         $error("adc_scka high while adc_mclk is high");
         failures++;
      end

   // a stalled word stays put until the sink takes it
   data_held_on_stall: assert property (@(posedge capture_clk) disable iff (external_reset)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else begin
         $error("out_data or out_valid changed while the sink stalled");
         failures++;
      end

endmodule

bind multi_adc_capture adc_capture_properties props (
   .capture_clk    (capture_clk),
   .external_reset (external_reset),
   .adc_mclk       (adc_mclk),
   .adc_scka       (adc_scka),
   .out_valid      (out_valid),
   .out_ready      (out_ready),
   .out_data       (out_data)
);

/* testbench/tb_multi_adc_capture.sv */
// testbench for the multi-channel ADC capture, models the ADCs and checks the output stream
`include "adc_capture_consts.svh"

module tb_multi_adc_capture;

   // twelve word periods cover every phase, the rest is margin for reset and draining
   localparam int timeout_cycles = 12 * `ADC_DECIMATE * `ADC_CYCLES + 400;

   logic                     capture_clk;
   logic                     external_reset;
   logic [`ADC_CHANNELS-1:0] adc_sdoa;
   logic                     out_ready;
   logic                     adc_mclk;
   logic                     adc_scka;
   logic                     adc_sync;
   logic                     out_valid;
   adc_data_pkg::out_word_t  out_data;
   logic                     overrun;

   integer seed = 32'h971a_dd6e;

   // ADC model, one word per channel is being read out at any time
   adc_data_pkg::sample_t model_words [`ADC_CHANNELS];
   adc_data_pkg::sample_t expected [$];
   int   bit_idx;
   logic armed;
   int   sets_model;
   int   sets_done = 0;
   // set while the sink is stalled, sets that finish then are lost to the overrun
   logic drop_sets = 1'b0;
   int   mclk_rises;
   int   sync_rises;
   logic mclk_last = 1'b0;
   logic sync_last = 1'b0;

   int value_errors = 0;
   int other_errors = 0;
   int timeout_errors = 0;
   int words_pushed = 0;
   int words_seen = 0;
   int cycle_count = 0;

   multi_adc_capture uut (
      .capture_clk    (capture_clk),
      .external_reset (external_reset),
      .adc_sdoa       (adc_sdoa),
      .out_ready      (out_ready),
      .adc_mclk       (adc_mclk),
      .adc_scka       (adc_scka),
      .adc_sync       (adc_sync),
      .out_valid      (out_valid),
      .out_data       (out_data),
      .overrun        (overrun)
   );

   // expected stream word, sample in the top bits and zero fill below
   function automatic adc_data_pkg::out_word_t left_justify(input adc_data_pkg::sample_t s);
      return {s, {(`OUT_WIDTH - `ADC_BITS){1'b0}}};
   endfunction

   task automatic check_word(input adc_data_pkg::out_word_t got,
                             input adc_data_pkg::out_word_t exp, input string name);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string name);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string name);
      if (got != exp) begin
         value_errors++;
         $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   // a fresh random sample for every channel
   task automatic draw_words();
      int r;
      for (int ch = 0; ch < `ADC_CHANNELS; ch++) begin
         r = $random(seed);
         model_words[ch] = r[`ADC_BITS-1:0];
      end
   endtask

   // waits until n more word sets have left the ADC model
   task automatic wait_sets(input int n, input logic random_ready);
      int target;
      int r;
      target = sets_done + n;
      while (sets_done < target) begin
         @(posedge capture_clk);
         if (random_ready) begin
            r = $random(seed);
            out_ready <= r[0];
         end
      end
   endtask

   task automatic finish_run();
      int assert_errors;
      assert_errors = uut.props.failures;
      $display("errors: value %0d, other %0d, assertion %0d, timeout %0d",
               value_errors, other_errors, assert_errors, timeout_errors);
      if (value_errors + other_errors + assert_errors + timeout_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   endtask

   initial begin
      capture_clk = 1'b0;
      forever #20 capture_clk = ~capture_clk;
   end

   // SYNC clocks out the MSB and every SCKA pulse the next bit, all pins seen before the edge
   // the reset SYNC only clears the ADC filter, so the model arms once it has fallen
   always @(posedge capture_clk) begin
      if (external_reset) begin
         armed      = 1'b0;
         bit_idx    = `ADC_BITS - 1;
         sets_model = 0;
         mclk_rises = 0;
         sync_rises = 0;
         draw_words();
      end else if (!armed) begin
         if (!adc_sync) armed = 1'b1;
      end else begin
         if (adc_mclk && !mclk_last) mclk_rises++;
         if (adc_sync && !sync_last) sync_rises++;
         if (adc_scka || adc_sync) begin
            if (bit_idx == 0) begin
               // one full word per ADC, every set spans ADC_DECIMATE conversions
               check_count(mclk_rises, `ADC_DECIMATE, "adc_mclk rising edges per word");
               check_count(sync_rises, 1, "adc_sync pulses per word");
               mclk_rises = 0;
               sync_rises = 0;
               if (!drop_sets) begin
                  for (int ch = 0; ch < `ADC_CHANNELS; ch++) begin
                     expected.push_back(model_words[ch]);
                     words_pushed++;
                  end
               end
               sets_model++;
               sets_done <= sets_model;
               draw_words();
               bit_idx = `ADC_BITS - 1;
            end else begin
               bit_idx--;
            end
         end
      end
      mclk_last = adc_mclk;
      sync_last = adc_sync;
      for (int ch = 0; ch < `ADC_CHANNELS; ch++) begin
         adc_sdoa[ch] <= model_words[ch][bit_idx];
      end
   end

   // every transfer takes the oldest expected word, which also checks the channel order
   always @(posedge capture_clk) begin
      if (!external_reset && out_valid && out_ready) begin
         if (expected.size() == 0) begin
            other_errors++;
            $display("time %0t: a word came out when none was expected", $time);
         end else begin
            check_word(out_data, left_justify(expected.pop_front()), "out_data");
         end
         words_seen++;
      end
   end

   initial begin
      while (cycle_count < timeout_cycles) begin
         @(posedge capture_clk);
         cycle_count++;
      end
      timeout_errors++;
      $display("time %0t: run did not finish within %0d cycles", $time, timeout_cycles);
      finish_run();
   end

   initial begin
      external_reset = 1'b1;
      out_ready      = 1'b0;
      adc_sdoa       = '0;
      repeat (3) @(posedge capture_clk);
      check_bit(adc_mclk, 1'b0, "adc_mclk");
      check_bit(adc_scka, 1'b0, "adc_scka");
      check_bit(adc_sync, 1'b1, "adc_sync");
      check_bit(out_valid, 1'b0, "out_valid");
      check_bit(overrun, 1'b0, "overrun");
      external_reset <= 1'b0;
      out_ready      <= 1'b1;
      // steady sink first, then a sink that stalls at random
      wait_sets(3, 1'b0);
      wait_sets(3, 1'b1);
      check_bit(overrun, 1'b0, "overrun");
      out_ready <= 1'b1;
      // stall right after a load, the two sets behind it find the chain full
      wait_sets(1, 1'b0);
      out_ready <= 1'b0;
      drop_sets <= 1'b1;
      wait_sets(2, 1'b0);
      check_bit(overrun, 1'b1, "overrun");
      out_ready <= 1'b1;
      drop_sets <= 1'b0;
      wait_sets(1, 1'b0);
      while (expected.size() != 0 || out_valid) @(posedge capture_clk);
      check_bit(overrun, 1'b1, "overrun");
      check_count(words_seen, words_pushed, "words received");
      finish_run();
   end

endmodule

/* verilog.f */
+incdir+hdl
hdl/adc_timing_pkg.sv
hdl/adc_data_pkg.sv
hdl/adc_sequencer.sv
hdl/adc_bit_gather.sv
hdl/adc_channel_shifter.sv
hdl/adc_word_serializer.sv
hdl/multi_adc_capture.sv
testbench/adc_capture_properties.sv
testbench/tb_multi_adc_capture.sv

/* Bender.yml */
package:
  name: multi_adc_capture

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/adc_timing_pkg.sv
      - hdl/adc_data_pkg.sv
      - hdl/adc_sequencer.sv
      - hdl/adc_bit_gather.sv
      - hdl/adc_channel_shifter.sv
      - hdl/adc_word_serializer.sv
      - hdl/multi_adc_capture.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/adc_capture_properties.sv
      - testbench/tb_multi_adc_capture.sv
